/* bench/mips_system_tb.sv */
`timescale 1ns/100ps

module mips_system_tb;

	localparam int NUM_TESTS = 5;
	localparam int KIND_ALU  = 0;
	localparam int KIND_MEM  = 1;
	localparam int KIND_CTRL = 2;
	localparam int RUN_LIMIT = 2000; // cycles per run before giving up
	localparam int SETTLE_LIMIT = 16; // cycles for the halt j to run once
	localparam int RUN_NS    = 40 * 5 * 4; // longest program, all lw
	localparam int LOAD_NS   = (sys_pkg::MEM_WORDS + 16) * 4; // full load plus reset
	// frozen cycles in the ena test can stretch a run, hence 2x
	localparam int WATCHDOG_NS = NUM_TESTS * (2 * RUN_NS + LOAD_NS + 100) + 16 * 4;

	logic                       clk;
	logic                       rstb;
	logic                       ena;
	logic                       load_wr;
	logic [sys_pkg::MEM_AW-1:0] load_addr;
	logic [31:0]                load_data;
	logic [31:0]                pc;
	logic [1023:0]              reg_file;

	logic [31:0] seed;
	logic [31:0] prog [64];   // current program image
	logic [31:0] saved [64];  // alu program, rerun with ena toggling
	int          prog_len;
	int          saved_len;
	logic [31:0] m_regs [32]; // reference model state
	logic [31:0] m_mem [sys_pkg::MEM_WORDS];
	logic [31:0] m_pc;
	int          errors;
	int          pass_count;
	int          fail_count;

	mips_system uut (
		.clk       (clk),
		.rstb      (rstb),
		.ena       (ena),
		.load_wr   (load_wr),
		.load_addr (load_addr),
		.load_data (load_data),
		.pc        (pc),
		.reg_file  (reg_file)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		#(WATCHDOG_NS);
		$display("run timed out at %0t ns, core never settled at its halt address", $time);
		$display("tests failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic int rand_below(input int n);
		logic [31:0] v;
		v = next_rand();
		return (v >> 8) % n; // low bits of an lcg are weak
	endfunction

	// filler outside the program, unique per word
	function automatic logic [31:0] fill_word(input int i);
		logic [31:0] v;
		v = i;
		return (v * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
	endfunction

	function automatic logic [31:0] enc_r(input isa_pkg::funct_t fn, input int rs, input int rt,
			input int rd, input int sh);
		return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic logic [31:0] enc_i(input isa_pkg::opcode_t op, input int rs, input int rt,
			input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	// target given as word index into the program
	function automatic logic [31:0] enc_j(input isa_pkg::opcode_t op, input int target);
		logic [31:0] t;
		t = sys_pkg::RESET_PC >> 2;
		t = t + target;
		return {op, t[25:0]};
	endfunction

	// random arithmetic, logic or shift op, never writes r0 or r28..r31
	function automatic logic [31:0] rand_alu();
		int sel;
		int rd;
		int rs;
		int rt;
		int imm;
		sel = rand_below(13);
		rd  = 1 + rand_below(27);
		rs  = rand_below(32);
		rt  = rand_below(32);
		imm = rand_below(65536);
		case (sel)
			0:       return enc_r(isa_pkg::fn_add, rs, rt, rd, 0);
			1:       return enc_r(isa_pkg::fn_sub, rs, rt, rd, 0);
			2:       return enc_r(isa_pkg::fn_and, rs, rt, rd, 0);
			3:       return enc_r(isa_pkg::fn_or, rs, rt, rd, 0);
			4:       return enc_r(isa_pkg::fn_xor, rs, rt, rd, 0);
			5:       return enc_r(isa_pkg::fn_nor, rs, rt, rd, 0);
			6:       return enc_r(isa_pkg::fn_slt, rs, rt, rd, 0);
			7:       return enc_r(isa_pkg::fn_sll, 0, rt, rd, imm % 32);
			8:       return enc_r(isa_pkg::fn_srl, 0, rt, rd, imm % 32);
			9:       return enc_i(isa_pkg::op_addi, rs, rd, imm);
			10:      return enc_i(isa_pkg::op_slti, rs, rd, imm);
			11:      return enc_i(isa_pkg::op_andi, rs, rd, imm);
			default: return enc_i(isa_pkg::op_ori, rs, rd, imm);
		endcase
	endfunction

	task automatic emit(input logic [31:0] word);
		prog[prog_len] = word;
		prog_len++;
	endtask

	// cnt instructions, forward branches land no further than the section end
	task automatic gen_section(input int kind, input int cnt);
		int end_idx;
		int idx;
		int r;
		int k;
		int kmax;
		int rs;
		int rt;
		end_idx = prog_len + cnt;
		repeat (cnt) begin
			idx  = prog_len;
			kmax = end_idx - idx - 1;
			if (kmax > 3)
				kmax = 3;
			r = rand_below(10);
			if (kind == KIND_MEM && r < 4) begin
				emit(enc_i(isa_pkg::op_sw, 28, rand_below(32), rand_below(16) * 4));
			end else if (kind == KIND_MEM && r < 7) begin
				emit(enc_i(isa_pkg::op_lw, 28, 1 + rand_below(27), rand_below(16) * 4));
			end else if (kind == KIND_CTRL && r < 4) begin
				k  = rand_below(kmax + 1);
				rs = rand_below(32);
				rt = rand_below(2) ? rs : rand_below(32); // equal regs half the time
				emit(enc_i(r < 2 ? isa_pkg::op_beq : isa_pkg::op_bne, rs, rt, k));
			end else if (kind == KIND_CTRL && r == 4) begin
				k = rand_below(kmax + 1);
				emit(enc_j(isa_pkg::op_j, idx + 1 + k));
			end else begin
				emit(rand_alu());
			end
		end
	endtask

	task automatic gen_program(input int kind);
		int i;
		int n_body;
		int sub_len;
		int blk;
		int pre;
		int jal_idx;
		prog_len = 0;
		emit(enc_i(isa_pkg::op_addi, 0, 28, 16'h0400)); // data base, word 256
		for (i = 1; i <= 6; i++)
			emit(enc_i(isa_pkg::op_addi, 0, i, rand_below(65536)));
		n_body = 16 + rand_below(17); // 24..40 words in total
		if (kind == KIND_CTRL) begin
			sub_len = 1 + rand_below(2);
			blk     = 4 + sub_len;
			pre     = (n_body - blk) / 2;
			gen_section(kind, pre);
			// jal sub; filler; j over sub; sub body; jr r31
			jal_idx = prog_len;
			emit(enc_j(isa_pkg::op_jal, jal_idx + 3));
			emit(rand_alu());
			emit(enc_j(isa_pkg::op_j, jal_idx + 4 + sub_len));
			repeat (sub_len)
				emit(rand_alu());
			emit(enc_r(isa_pkg::fn_jr, 31, 0, 0, 0));
			gen_section(kind, n_body - blk - pre);
		end else begin
			gen_section(kind, n_body);
		end
		emit(enc_j(isa_pkg::op_j, prog_len)); // halt, jumps to itself
	endtask

	// whole memory rewritten through the load port, mirrored in the model
	task automatic load_memory();
		int i;
		logic [31:0] word;
		for (i = 0; i < sys_pkg::MEM_WORDS; i++) begin
			word      = (i < prog_len) ? prog[i] : fill_word(i);
			m_mem[i]  = word;
			load_wr   = 1'b1;
			load_addr = i[sys_pkg::MEM_AW-1:0];
			load_data = word;
			@(negedge clk);
		end
		load_wr = 1'b0;
	endtask

	task automatic pulse_reset();
		rstb = 1'b1;
		repeat (16) @(negedge clk);
		rstb = 1'b0;
	endtask

	task automatic report_mismatch(input string sig, input logic [31:0] exp,
			input logic [31:0] got);
		$display("FAILED at %0t ns: %s expected %h got %h", $time, sig, exp, got);
		errors++;
	endtask

	// reference isa model, runs from the reset pc up to the halt
	task automatic model_run(input logic [31:0] halt_addr);
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_s;
		logic [31:0] imm_z;
		logic [31:0] next_pc;
		logic [31:0] addr;
		logic [31:0] res;
		logic [4:0]  dst;
		bit          wr;
		int          steps;
		int          i;
		for (i = 0; i < 32; i++)
			m_regs[i] = 32'h0;
		m_pc  = sys_pkg::RESET_PC;
		steps = 0;
		while (m_pc != halt_addr && steps < 1000) begin
			ins     = m_mem[m_pc[11:2]];
			a       = m_regs[ins[25:21]];
			b       = m_regs[ins[20:16]];
			imm_s   = {{16{ins[15]}}, ins[15:0]};
			imm_z   = {16'h0, ins[15:0]};
			next_pc = m_pc + 4;
			wr      = 1'b1;
			dst     = ins[20:16]; // rt unless overridden
			res     = 32'h0;
			case (ins[31:26])
				isa_pkg::op_rtype: begin
					dst = ins[15:11];
					case (ins[5:0])
						isa_pkg::fn_add: res = a + b;
						isa_pkg::fn_sub: res = a - b;
						isa_pkg::fn_and: res = a & b;
						isa_pkg::fn_or:  res = a | b;
						isa_pkg::fn_xor: res = a ^ b;
						isa_pkg::fn_nor: res = ~(a | b);
						isa_pkg::fn_slt: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						isa_pkg::fn_sll: res = b << ins[10:6];
						isa_pkg::fn_srl: res = b >> ins[10:6];
						isa_pkg::fn_jr: begin
							wr      = 1'b0;
							next_pc = a;
						end
						default: wr = 1'b0;
					endcase
				end
				isa_pkg::op_addi: res = a + imm_s;
				isa_pkg::op_slti: res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
				isa_pkg::op_andi: res = a & imm_z;
				isa_pkg::op_ori:  res = a | imm_z;
				isa_pkg::op_lw: begin
					addr = a + imm_s;
					res  = m_mem[addr[11:2]]; // 4 KB window, aliases above
				end
				isa_pkg::op_sw: begin
					wr   = 1'b0;
					addr = a + imm_s;
					m_mem[addr[11:2]] = b;
				end
				isa_pkg::op_beq: begin
					wr = 1'b0;
					if (a == b)
						next_pc = next_pc + (imm_s << 2);
				end
				isa_pkg::op_bne: begin
					wr = 1'b0;
					if (a != b)
						next_pc = next_pc + (imm_s << 2);
				end
				isa_pkg::op_j: begin
					wr      = 1'b0;
					next_pc = {next_pc[31:28], ins[25:0], 2'b00};
				end
				isa_pkg::op_jal: begin
					dst     = 5'd31;
					res     = next_pc; // return address pc+4
					next_pc = {next_pc[31:28], ins[25:0], 2'b00};
				end
				default: wr = 1'b0;
			endcase
			if (wr && dst != 5'd0)
				m_regs[dst] = res;
			m_pc = next_pc;
			steps++;
		end
	endtask

	task automatic check_regs();
		int i;
		for (i = 0; i < 32; i++)
			if (reg_file[i*32 +: 32] !== m_regs[i])
				report_mismatch($sformatf("reg_file[r%0d]", i), m_regs[i], reg_file[i*32 +: 32]);
	endtask

	task automatic run_program(input bit toggle_ena, input bit check_reset);
		logic [31:0] halt_off;
		logic [31:0] halt_addr;
		logic [31:0] held_pc;
		int          cycles;
		int          i;
		halt_off  = prog_len - 1;
		halt_addr = sys_pkg::RESET_PC + (halt_off << 2);
		ena = 1'b0; // core frozen while the program loads
		load_memory();
		pulse_reset();
		if (check_reset) begin
			if (pc !== sys_pkg::RESET_PC)
				report_mismatch("pc", sys_pkg::RESET_PC, pc);
			for (i = 0; i < 32; i++)
				if (reg_file[i*32 +: 32] !== 32'h0)
					report_mismatch($sformatf("reg_file[r%0d]", i), 32'h0, reg_file[i*32 +: 32]);
		end
		model_run(halt_addr);
		cycles  = 0;
		held_pc = pc;
		while (pc !== halt_addr && cycles < RUN_LIMIT) begin
			if (toggle_ena) begin
				if (!ena && pc !== held_pc)
					report_mismatch("pc", held_pc, pc); // moved while frozen
				ena     = (rand_below(4) != 0); // low about a quarter of the time
				held_pc = pc;
			end else begin
				ena = 1'b1;
			end
			@(negedge clk);
			cycles++;
		end
		if (cycles >= RUN_LIMIT) begin
			$display("core did not reach the halt address %h within %0d cycles", halt_addr,
				RUN_LIMIT);
			errors++;
		end else begin
			// first sight of the halt pc can precede the last writeback
			// pc steps past the halt word when it is fetched and comes back once the j runs
			ena    = 1'b1;
			cycles = 0;
			while (pc !== halt_addr + 32'd4 && cycles < SETTLE_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			while (pc !== halt_addr && cycles < SETTLE_LIMIT) begin
				@(negedge clk);
				cycles++;
			end
			if (cycles >= SETTLE_LIMIT) begin
				$display("core did not run the halt jump at %h within %0d cycles", halt_addr,
					SETTLE_LIMIT);
				errors++;
			end
			if (pc !== halt_addr)
				report_mismatch("pc", halt_addr, pc);
			check_regs();
		end
		ena = 1'b0;
	endtask

	task automatic finish_test(input string name);
		if (errors == 0) begin
			pass_count++;
			$display("test %-14s passed", name);
		end else begin
			fail_count++;
			$display("test %-14s failed with %0d errors", name, errors);
		end
		errors = 0;
	endtask

	initial begin
		rstb       = 1'b1;
		ena        = 1'b0;
		load_wr    = 1'b0;
		load_addr  = '0;
		load_data  = 32'h0;
		seed       = 32'h3398_4414;
		errors     = 0;
		pass_count = 0;
		fail_count = 0;
		repeat (16) @(negedge clk);
		rstb = 1'b0;

		gen_program(KIND_ALU);
		saved     = prog;
		saved_len = prog_len;
		run_program(1'b0, 1'b0);
		finish_test("alu");

		gen_program(KIND_MEM);
		run_program(1'b0, 1'b0);
		finish_test("memory");

		gen_program(KIND_CTRL);
		run_program(1'b0, 1'b0);
		finish_test("control flow");

		prog     = saved; // same alu program, now with stalls
		prog_len = saved_len;
		run_program(1'b1, 1'b0);
		finish_test("ena freeze");

		// reload over a used core, reset must clear pc and registers
		gen_program(KIND_CTRL);
		run_program(1'b0, 1'b1);
		finish_test("reload reset");

		$display("%0d tests run, %0d passed, %0d failed", NUM_TESTS, pass_count, fail_count);
		if (fail_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* hdl/alu.sv */
`timescale 1ns/100ps

module alu (
	input  logic [31:0]      a,
	input  logic [31:0]      b,
	input  isa_pkg::alu_op_t op,
	output logic [31:0]      result,
	output logic             zero
);

	always_comb begin
		case (op)
			isa_pkg::alu_and: result = a & b;
			isa_pkg::alu_or:  result = a | b;
			isa_pkg::alu_add: result = a + b;
			isa_pkg::alu_xor: result = a ^ b;
			isa_pkg::alu_nor: result = ~(a | b);
			isa_pkg::alu_sub: result = a - b;
			// signed compare
			isa_pkg::alu_slt: result = {31'b0, $signed(a) < $signed(b)};
			isa_pkg::alu_sll: result = b << a[4:0]; // amount in a
			isa_pkg::alu_srl: result = b >> a[4:0]; // logical
			default:          result = a + b;
		endcase
	end

	// branch compare uses sub
	assign zero = (result == 32'b0);

endmodule

/* hdl/control_unit.sv */
`timescale 1ns/100ps

module control_unit (
	input  logic              clk,
	input  logic              rstb,
	input  logic              ena,
	input  logic [31:0]       instr,
	output logic              mem_wr,
	output logic              ir_wr,
	output logic              pc_wr,
	output logic              reg_wr,
	output logic              mem_to_reg,
	output logic [1:0]        reg_dst,
	output logic              iord,
	output logic [1:0]        alu_src_a,
	output logic [1:0]        alu_src_b,
	output logic [1:0]        pc_src,
	output logic [1:0]        branch,
	output logic              zero_ext,
	output isa_pkg::alu_op_t  alu_ctrl
);

	isa_pkg::state_t  state;
	isa_pkg::state_t  next_state;
	isa_pkg::opcode_t op;
	isa_pkg::funct_t  fn;
	isa_pkg::alu_op_t r_alu; // alu op from funct
	isa_pkg::alu_op_t i_alu; // alu op from opcode
	logic             fn_valid;
	logic             is_shift;

	assign op = isa_pkg::opcode_t'(instr[31:26]);
	assign fn = isa_pkg::funct_t'(instr[5:0]);

	// sll/srl take the shift amount as operand a
	assign is_shift = (fn == isa_pkg::fn_sll) || (fn == isa_pkg::fn_srl);

	always_comb begin
		fn_valid = 1'b1;
		case (fn)
			isa_pkg::fn_add: r_alu = isa_pkg::alu_add;
			isa_pkg::fn_sub: r_alu = isa_pkg::alu_sub;
			isa_pkg::fn_and: r_alu = isa_pkg::alu_and;
			isa_pkg::fn_or:  r_alu = isa_pkg::alu_or;
			isa_pkg::fn_xor: r_alu = isa_pkg::alu_xor;
			isa_pkg::fn_nor: r_alu = isa_pkg::alu_nor;
			isa_pkg::fn_slt: r_alu = isa_pkg::alu_slt;
			isa_pkg::fn_sll: r_alu = isa_pkg::alu_sll;
			isa_pkg::fn_srl: r_alu = isa_pkg::alu_srl;
			default: begin
				r_alu    = isa_pkg::alu_add;
				fn_valid = 1'b0; // includes jr, handled apart
			end
		endcase
	end

	always_comb begin
		case (op)
			isa_pkg::op_slti: i_alu = isa_pkg::alu_slt;
			isa_pkg::op_andi: i_alu = isa_pkg::alu_and;
			isa_pkg::op_ori:  i_alu = isa_pkg::alu_or;
			default:          i_alu = isa_pkg::alu_add; // addi
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstb)
			state <= isa_pkg::st_fetch;
		else if (ena)
			state <= next_state; // frozen while ena low
	end

	always_comb begin
		next_state = isa_pkg::st_fetch; // most states end here
		case (state)
			isa_pkg::st_fetch: next_state = isa_pkg::st_decode;
			isa_pkg::st_decode: begin
				case (op)
					isa_pkg::op_rtype: begin
						if (fn == isa_pkg::fn_jr)
							next_state = isa_pkg::st_jr;
						else if (fn_valid)
							next_state = isa_pkg::st_r_exec;
					end
					isa_pkg::op_lw,
					isa_pkg::op_sw:   next_state = isa_pkg::st_mem_addr;
					isa_pkg::op_addi,
					isa_pkg::op_slti,
					isa_pkg::op_andi,
					isa_pkg::op_ori:  next_state = isa_pkg::st_i_exec;
					isa_pkg::op_beq,
					isa_pkg::op_bne:  next_state = isa_pkg::st_branch;
					isa_pkg::op_j:    next_state = isa_pkg::st_jump;
					isa_pkg::op_jal:  next_state = isa_pkg::st_jal;
					default:          next_state = isa_pkg::st_fetch; // unknown opcode
				endcase
			end
			isa_pkg::st_mem_addr:
				next_state = (op == isa_pkg::op_lw) ? isa_pkg::st_mem_read : isa_pkg::st_mem_write;
			isa_pkg::st_mem_read:  next_state = isa_pkg::st_mem_writeback;
			isa_pkg::st_r_exec:    next_state = isa_pkg::st_r_writeback;
			isa_pkg::st_i_exec:    next_state = isa_pkg::st_i_writeback;
			default:               next_state = isa_pkg::st_fetch;
		endcase
	end

	always_comb begin
		mem_wr     = 1'b0;
		ir_wr      = 1'b0;
		pc_wr      = 1'b0;
		reg_wr     = 1'b0;
		mem_to_reg = 1'b0;
		reg_dst    = 2'b00;   // rt
		iord       = 1'b0;    // address from pc
		alu_src_a  = 2'b00;   // pc
		alu_src_b  = 2'b00;   // b
		pc_src     = 2'b00;   // alu result
		branch     = 2'b00;
		zero_ext   = 1'b0;
		alu_ctrl   = isa_pkg::alu_add;
		case (state)
			isa_pkg::st_fetch: begin
				ir_wr     = 1'b1;
				pc_wr     = 1'b1;
				alu_src_b = 2'b01; // pc + 4
			end
			isa_pkg::st_decode: alu_src_b = 2'b11; // branch target into aluout
			isa_pkg::st_mem_addr: begin
				alu_src_a = 2'b01;
				alu_src_b = 2'b10; // base + offset
			end
			isa_pkg::st_mem_read: iord = 1'b1; // mdr captures the word
			isa_pkg::st_mem_writeback: begin
				mem_to_reg = 1'b1;
				reg_wr     = 1'b1;
			end
			isa_pkg::st_mem_write: begin
				iord   = 1'b1;
				mem_wr = 1'b1;
			end
			isa_pkg::st_r_exec: begin
				alu_src_a = is_shift ? 2'b10 : 2'b01;
				alu_ctrl  = r_alu;
			end
			isa_pkg::st_r_writeback: begin
				reg_dst = 2'b01; // rd
				reg_wr  = 1'b1;
			end
			isa_pkg::st_i_exec: begin
				alu_src_a = 2'b01;
				alu_src_b = 2'b10;
				zero_ext  = (op == isa_pkg::op_andi) || (op == isa_pkg::op_ori);
				alu_ctrl  = i_alu;
			end
			isa_pkg::st_i_writeback: reg_wr = 1'b1;
			isa_pkg::st_branch: begin
				alu_src_a = 2'b01;
				alu_ctrl  = isa_pkg::alu_sub; // compare a and b
				pc_src    = 2'b01;            // target from decode
				branch    = (op == isa_pkg::op_bne) ? 2'b10 : 2'b01;
			end
			isa_pkg::st_jump: begin
				pc_wr  = 1'b1;
				pc_src = 2'b10;
			end
			isa_pkg::st_jal: begin
				pc_wr   = 1'b1;
				pc_src  = 2'b10;
				reg_dst = 2'b10; // r31 gets pc+4
				reg_wr  = 1'b1;
			end
			isa_pkg::st_jr: begin
				pc_wr  = 1'b1;
				pc_src = 2'b11;
			end
			default: ;
		endcase
		// no strobes while frozen
		if (!ena) begin
			mem_wr = 1'b0;
			ir_wr  = 1'b0;
			pc_wr  = 1'b0;
			reg_wr = 1'b0;
			branch = 2'b00;
		end
	end

endmodule

/* hdl/isa_pkg.sv */
package isa_pkg;

	// primary opcode, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j     = 6'h02,
		op_jal   = 6'h03,
		op_beq   = 6'h04,
		op_bne   = 6'h05,
		op_addi  = 6'h08,
		op_slti  = 6'h0a,
		op_andi  = 6'h0c,
		op_ori   = 6'h0d,
		op_lw    = 6'h23,
		op_sw    = 6'h2b
	} opcode_t;

	// r-type funct, instr[5:0]
	typedef enum logic [5:0] {
		fn_sll = 6'h00,
		fn_srl = 6'h02,
		fn_jr  = 6'h08,
		fn_add = 6'h20,
		fn_sub = 6'h22,
		fn_and = 6'h24,
		fn_or  = 6'h25,
		fn_xor = 6'h26,
		fn_nor = 6'h27,
		fn_slt = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		alu_and = 4'd0,
		alu_or  = 4'd1,
		alu_add = 4'd2,
		alu_xor = 4'd3,
		alu_nor = 4'd4,
		alu_sub = 4'd6,
		alu_slt = 4'd7,
		alu_sll = 4'd8,
		alu_srl = 4'd9
	} alu_op_t;

	typedef enum logic [3:0] {
		st_fetch, st_decode,
		st_mem_addr, st_mem_read, st_mem_writeback, st_mem_write,
		st_r_exec, st_r_writeback,
		st_i_exec, st_i_writeback,
		st_branch, st_jump, st_jal, st_jr
	} state_t;

	// lsb of each 5-bit field
	localparam int RS_LSB    = 21;
	localparam int RT_LSB    = 16;
	localparam int RD_LSB    = 11;
	localparam int SHAMT_LSB = 6;

endpackage

/* hdl/mips.sv */
`timescale 1ns/100ps

module mips (
	input  logic          clk,
	input  logic          rstb,
	input  logic          ena,
	input  logic [31:0]   mem_rd_data,
	output logic [31:0]   mem_addr,
	output logic [31:0]   mem_wr_data,
	output logic          mem_wr_ena,
	output logic [31:0]   pc,
	output logic [1023:0] reg_file
);

	// control strobes and selects
	logic             pc_wr, iord, mem_wr, mem_to_reg, ir_wr, reg_wr, zero_ext;
	logic [1:0]       branch, pc_src, alu_src_a, alu_src_b, reg_dst;
	isa_pkg::alu_op_t alu_ctrl;

	// architectural and staging registers
	logic [31:0] ir, mdr, reg_a, reg_b, alu_out;

	logic [31:0] src_a, src_b, alu_result;
	logic        zero;
	logic [31:0] ext_imm;
	logic [4:0]  wr_addr;
	logic [31:0] wr_data;
	logic [31:0] rd_data1, rd_data2;
	logic        pc_en;
	logic [31:0] pc_next;

	control_unit u_ctrl (
		.clk        (clk),
		.rstb       (rstb),
		.ena        (ena),
		.instr      (ir),
		.mem_wr     (mem_wr),
		.ir_wr      (ir_wr),
		.pc_wr      (pc_wr),
		.reg_wr     (reg_wr),
		.mem_to_reg (mem_to_reg),
		.reg_dst    (reg_dst),
		.iord       (iord),
		.alu_src_a  (alu_src_a),
		.alu_src_b  (alu_src_b),
		.pc_src     (pc_src),
		.branch     (branch),
		.zero_ext   (zero_ext),
		.alu_ctrl   (alu_ctrl)
	);

	// immediate, sign or zero extended
	assign ext_imm = zero_ext ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

	always_comb begin
		case (alu_src_a)
			2'b00:   src_a = pc;
			2'b10:   src_a = {27'b0, ir[isa_pkg::SHAMT_LSB +: 5]}; // shamt
			default: src_a = reg_a;
		endcase
		case (alu_src_b)
			2'b00:   src_b = reg_b;
			2'b01:   src_b = 32'd4;
			2'b10:   src_b = ext_imm;
			default: src_b = {ext_imm[29:0], 2'b00}; // word offset
		endcase
	end

	alu u_alu (
		.a      (src_a),
		.b      (src_b),
		.op     (alu_ctrl),
		.result (alu_result),
		.zero   (zero)
	);

	// writeback target and data
	always_comb begin
		case (reg_dst)
			2'b01:   wr_addr = ir[isa_pkg::RD_LSB +: 5];
			2'b10:   wr_addr = 5'd31; // jal link
			default: wr_addr = ir[isa_pkg::RT_LSB +: 5];
		endcase
		if (reg_dst == 2'b10)
			wr_data = pc; // already pc+4 here
		else
			wr_data = mem_to_reg ? mdr : alu_out;
	end

	register_file u_rf (
		.clk      (clk),
		.rstb     (rstb),
		.rd_addr1 (ir[isa_pkg::RS_LSB +: 5]),
		.rd_addr2 (ir[isa_pkg::RT_LSB +: 5]),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.wr_ena   (reg_wr),
		.rd_data1 (rd_data1),
		.rd_data2 (rd_data2),
		.all_regs (reg_file)
	);

	// beq on zero, bne on not zero
	assign pc_en = pc_wr | (branch[0] & zero) | (branch[1] & ~zero);

	always_comb begin
		case (pc_src)
			2'b00:   pc_next = alu_result;
			2'b01:   pc_next = alu_out;
			2'b10:   pc_next = {pc[31:28], ir[25:0], 2'b00}; // j target
			default: pc_next = reg_a; // jr
		endcase
	end

	always_ff @(posedge clk) begin
		if (rstb) begin
			pc      <= sys_pkg::RESET_PC;
			ir      <= 32'b0;
			mdr     <= 32'b0;
			reg_a   <= 32'b0;
			reg_b   <= 32'b0;
			alu_out <= 32'b0;
		end else if (ena) begin
			mdr     <= mem_rd_data;
			reg_a   <= rd_data1;
			reg_b   <= rd_data2;
			alu_out <= alu_result;
			if (ir_wr)
				ir <= mem_rd_data;
			if (pc_en)
				pc <= pc_next;
		end
	end

	// single memory port
	assign mem_addr    = iord ? alu_out : pc;
	assign mem_wr_data = reg_b; // sw data only from b
	assign mem_wr_ena  = mem_wr;

endmodule

/* hdl/mips_system.sv */
`timescale 1ns/100ps

module mips_system (
	input  logic                       clk,
	input  logic                       rstb,
	input  logic                       ena,
	input  logic                       load_wr,
	input  logic [sys_pkg::MEM_AW-1:0] load_addr,
	input  logic [31:0]                load_data,
	output logic [31:0]                pc,
	output logic [1023:0]              reg_file
);

	// core side of the memory port
	logic [31:0] mem_addr, mem_wr_data, mem_rd_data;
	logic        mem_wr_ena;

	mips u_core (
		.clk         (clk),
		.rstb        (rstb),
		.ena         (ena),
		.mem_rd_data (mem_rd_data),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena),
		.pc          (pc),
		.reg_file    (reg_file)
	);

	unified_memory u_mem (
		.clk         (clk),
		.mem_addr    (mem_addr),
		.mem_wr_data (mem_wr_data),
		.mem_wr_ena  (mem_wr_ena),
		.mem_rd_data (mem_rd_data),
		.load_wr     (load_wr),
		.load_addr   (load_addr),
		.load_data   (load_data)
	);

endmodule

/* hdl/register_file.sv */
`timescale 1ns/100ps

module register_file (
	input  logic          clk,
	input  logic          rstb,
	input  logic [4:0]    rd_addr1,
	input  logic [4:0]    rd_addr2,
	input  logic [4:0]    wr_addr,
	input  logic [31:0]   wr_data,
	input  logic          wr_ena,
	output logic [31:0]   rd_data1,
	output logic [31:0]   rd_data2,
	output logic [1023:0] all_regs
);

	logic [31:0] regs [32];

	always_ff @(posedge clk) begin
		if (rstb) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'b0;
		end else if (wr_ena && (wr_addr != 5'd0)) begin
			regs[wr_addr] <= wr_data; // r0 stays zero
		end
	end

	// async reads
	assign rd_data1 = regs[rd_addr1];
	assign rd_data2 = regs[rd_addr2];

	// flat view, r0 in the low word
	for (genvar g = 0; g < 32; g++) begin : g_flat
		assign all_regs[g*32 +: 32] = regs[g];
	end

endmodule

/* hdl/sys_pkg.sv */
package sys_pkg;

	// unified program and data memory
	localparam int MEM_WORDS = 1024;
	localparam int MEM_AW    = 10; // word index width, byte addr bits [11:2]

	// first fetch address, lands on word 0
	localparam logic [31:0] RESET_PC = 32'h0040_0000;

endpackage

/* hdl/unified_memory.sv */
`timescale 1ns/100ps

module unified_memory (
	input  logic                      clk,
	input  logic [31:0]               mem_addr,
	input  logic [31:0]               mem_wr_data,
	input  logic                      mem_wr_ena,
	output logic [31:0]               mem_rd_data,
	input  logic                      load_wr,
	input  logic [sys_pkg::MEM_AW-1:0] load_addr,
	input  logic [31:0]               load_data
);

	logic [31:0]               ram [sys_pkg::MEM_WORDS];
	logic [sys_pkg::MEM_AW-1:0] word_idx;

	// byte address to word index
	assign word_idx = mem_addr[sys_pkg::MEM_AW+1:2];

	always_ff @(posedge clk) begin
		if (load_wr)
			ram[load_addr] <= load_data; // load port wins
		else if (mem_wr_ena)
			ram[word_idx] <= mem_wr_data;
	end

	// same cycle read
	assign mem_rd_data = ram[word_idx];

endmodule

/* mips_system.f */
hdl/isa_pkg.sv
hdl/sys_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/control_unit.sv
hdl/mips.sv
hdl/unified_memory.sv
hdl/mips_system.sv
bench/mips_system_tb.sv
